//--- cache_pkg.sv
// Shared definitions for the two-way write-back data cache.
// Geometry, memory message formats, address views and controller states.
`default_nettype none

package cache_pkg;

  // ==========================================================
  // Geometry
  // ==========================================================
  localparam int num_sets       = 8;
  localparam int num_ways       = 2;
  localparam int words_per_line = 4;

  localparam int idx_bits = $clog2(num_sets);
  localparam int off_bits = $clog2(words_per_line);
  localparam int tag_bits = 32 - idx_bits - off_bits - 2;

  // ==========================================================
  // Memory messages
  // ==========================================================
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_e;

  typedef struct packed {
    mem_type_e   type_;
    logic [7:0]  opaque;
    logic [31:0] addr;
    logic [1:0]  len;
    logic [31:0] data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e   type_;
    logic [7:0]  opaque;
    logic [1:0]  test;
    logic [1:0]  len;
    logic [31:0] data;
  } mem_resp_t;

  // Byte address seen either as one word or split into cache fields
  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [idx_bits-1:0] index;
    logic [off_bits-1:0] word_off;
    logic [1:0]          byte_off;
  } addr_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t f;
  } cache_addr_u;

  // ==========================================================
  // Controller and datapath interface
  // ==========================================================
  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_respond,
    st_spill,
    st_refill_req,
    st_refill_wait,
    st_write_data,
    st_flush_scan,
    st_flush_spill,
    st_flush_done
  } ctrl_state_e;

  typedef struct packed {
    logic req_en;     // capture accepted request
    logic resp_en;    // capture response word
    logic tag_en;
    logic tag_wen;
    logic lru_wen;
    logic data_en;
    logic data_wen;
    logic wdata_sel;  // 1 selects the refill word
    logic spill_sel;  // 1 selects victim address and write type
    logic word_clr;
    logic word_step;
    logic set_step;
  } dpath_ctrl_t;

  typedef struct packed {
    logic      hit;
    logic      hit_way;
    logic      victim_dirty;
    logic      victim_way;
    logic      last_word;
    logic      last_set;
    mem_type_e req_type;
  } dpath_status_t;

endpackage

`default_nettype wire

//--- cache_tag_array.sv
// Tag store for both ways with valid, dirty and per-set LRU bits.
// Reads are registered; a write also refreshes the read outputs of its way.
`default_nettype none

module cache_tag_array (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           en,
  input  logic                           wen,
  input  logic                           way,
  input  logic [cache_pkg::idx_bits-1:0] index,
  input  logic [cache_pkg::tag_bits-1:0] tag_in,
  input  logic                           dirty_in,
  input  logic                           lru_wen,
  input  logic                           lru_in,
  output logic [cache_pkg::tag_bits-1:0] tag_out0,
  output logic [cache_pkg::tag_bits-1:0] tag_out1,
  output logic [cache_pkg::num_ways-1:0] valid_out,
  output logic [cache_pkg::num_ways-1:0] dirty_out,
  output logic                           lru_out
);
  import cache_pkg::*;

  logic [tag_bits-1:0]                 tags [num_ways][num_sets];
  logic [num_ways-1:0][num_sets-1:0]   valid_q;
  logic [num_ways-1:0][num_sets-1:0]   dirty_q;
  logic [num_sets-1:0]                 lru_q;

  // State bits and their read registers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      lru_q     <= '0;
      valid_out <= '0;
      dirty_out <= '0;
      lru_out   <= 1'b0;
    end else begin
      if (en) begin
        for (int w = 0; w < num_ways; w++) begin
          valid_out[w] <= valid_q[w][index];
          dirty_out[w] <= dirty_q[w][index];
        end
        lru_out <= lru_q[index];
      end
      if (wen) begin
        valid_q[way][index] <= 1'b1;
        dirty_q[way][index] <= dirty_in;
        valid_out[way]      <= 1'b1;
        dirty_out[way]      <= dirty_in;
      end
      if (lru_wen) begin
        lru_q[index] <= lru_in;
        lru_out      <= lru_in;
      end
    end
  end

  // Tag storage
  always_ff @(posedge clk) begin
    if (en) begin
      tag_out0 <= tags[0][index];
      tag_out1 <= tags[1][index];
    end
    if (wen) begin
      tags[way][index] <= tag_in;
      if (way) begin
        tag_out1 <= tag_in;
      end else begin
        tag_out0 <= tag_in;
      end
    end
  end

endmodule

`default_nettype wire

//--- cache_data_array.sv
// Line storage for both ways, one word read from each way per access.
`default_nettype none

module cache_data_array (
  input  logic                           clk,
  input  logic                           en,
  input  logic                           wen,
  input  logic                           way,
  input  logic [cache_pkg::idx_bits-1:0] index,
  input  logic [cache_pkg::off_bits-1:0] offset,
  input  logic [31:0]                    wdata,
  output logic [31:0]                    rdata0,
  output logic [31:0]                    rdata1
);
  import cache_pkg::*;

  logic [31:0] mem [num_ways][num_sets][words_per_line];

  // Read returns the old word when the same word is written
  always_ff @(posedge clk) begin
    if (en) begin
      if (wen) begin
        mem[way][index][offset] <= wdata;
      end
      rdata0 <= mem[0][index][offset];
      rdata1 <= mem[1][index][offset];
    end
  end

endmodule

`default_nettype wire

//--- cache_dpath.sv
// Cache datapath: request capture, lookup, victim choice, counters
// and assembly of the processor and memory messages.
`default_nettype none

module cache_dpath (
  input  logic                     clk,
  input  logic                     arst_n,
  input  cache_pkg::mem_req_t      memreq_msg,
  input  cache_pkg::mem_resp_t     cache_resp_msg,
  input  cache_pkg::dpath_ctrl_t   ctrl,
  input  cache_pkg::ctrl_state_e   state,
  output cache_pkg::mem_resp_t     memresp_msg,
  output cache_pkg::mem_req_t      cache_req_msg,
  output cache_pkg::dpath_status_t status
);
  import cache_pkg::*;

  mem_req_t            req_q;
  logic [31:0]         resp_data_q;
  logic [off_bits-1:0] word_cnt;
  logic [idx_bits-1:0] set_cnt;
  cache_addr_u         in_addr;
  cache_addr_u         req_addr;
  cache_addr_u         mem_addr;
  logic [idx_bits-1:0] idx;
  logic [off_bits-1:0] off;
  logic [off_bits-1:0] word_ahead;
  logic [tag_bits-1:0] tag0;
  logic [tag_bits-1:0] tag1;
  logic [num_ways-1:0] valid;
  logic [num_ways-1:0] dirty;
  logic [num_ways-1:0] match;
  logic                lru;
  logic                in_flush;
  logic                proc_write;
  logic                victim_way;
  logic                wr_way;
  logic                resp_load;
  logic [31:0]         rdata0;
  logic [31:0]         rdata1;

  assign in_addr.raw  = memreq_msg.addr;
  assign req_addr.raw = req_q.addr;
  assign in_flush     = (state == st_flush_scan) || (state == st_flush_spill);
  assign proc_write   = ctrl.data_wen && !ctrl.wdata_sel;
  // Spill reads run one word ahead of the word being sent
  assign word_ahead   = word_cnt + off_bits'(ctrl.spill_sel && ctrl.word_step);

  // ==========================================================
  // Array addressing
  // ==========================================================
  always_comb begin
    if (state == st_idle) begin
      idx = ctrl.req_en ? in_addr.f.index : set_cnt;
    end else if (in_flush) begin
      idx = set_cnt + idx_bits'(ctrl.set_step);
    end else begin
      idx = req_addr.f.index;
    end
  end

  always_comb begin
    if (state == st_idle) begin
      off = in_addr.f.word_off;
    end else if (proc_write) begin
      off = req_addr.f.word_off;
    end else begin
      off = word_ahead;
    end
  end

  // ==========================================================
  // Lookup and victim
  // ==========================================================
  assign match[0] = valid[0] && (tag0 == req_addr.f.tag);
  assign match[1] = valid[1] && (tag1 == req_addr.f.tag);

  // Flush takes the first dirty way, otherwise the LRU way is evicted
  assign victim_way = in_flush ? !(valid[0] && dirty[0]) : lru;
  assign wr_way     = (state == st_tag_check || state == st_write_data) ? status.hit_way
                                                                       : status.victim_way;

  assign status.hit          = |match;
  assign status.hit_way      = match[1];
  assign status.victim_dirty = valid[victim_way] && dirty[victim_way];
  assign status.victim_way   = victim_way;
  assign status.last_word    = (word_cnt == off_bits'(words_per_line - 1));
  assign status.last_set     = (set_cnt == idx_bits'(num_sets - 1));
  assign status.req_type     = req_q.type_;

  // ==========================================================
  // Registers and counters
  // ==========================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_cnt <= '0;
      set_cnt  <= '0;
    end else begin
      if (ctrl.word_clr) begin
        word_cnt <= '0;
      end else if (ctrl.word_step) begin
        word_cnt <= word_cnt + 1'b1;
      end
      if (ctrl.set_step) begin
        set_cnt <= set_cnt + 1'b1;
      end
    end
  end

  // Refill only keeps the word the processor asked for
  assign resp_load = ctrl.resp_en &&
                     (state != st_refill_wait || word_cnt == req_addr.f.word_off);

  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_q <= memreq_msg;
    end
    if (resp_load) begin
      resp_data_q <= (state == st_refill_wait) ? cache_resp_msg.data
                   : (status.hit_way ? rdata1 : rdata0);
    end
  end

  // ==========================================================
  // Messages
  // ==========================================================
  always_comb begin
    mem_addr.f.tag      = ctrl.spill_sel ? (status.victim_way ? tag1 : tag0) : req_addr.f.tag;
    mem_addr.f.index    = idx;
    mem_addr.f.word_off = word_cnt;
    mem_addr.f.byte_off = 2'b00;
  end

  assign cache_req_msg.type_  = ctrl.spill_sel ? mem_write : mem_read;
  assign cache_req_msg.opaque = '0;
  assign cache_req_msg.addr   = mem_addr.raw;
  assign cache_req_msg.len    = '0;
  assign cache_req_msg.data   = status.victim_way ? rdata1 : rdata0;

  assign memresp_msg.type_  = req_q.type_;
  assign memresp_msg.opaque = '0;
  assign memresp_msg.test   = '0;
  assign memresp_msg.len    = '0;
  assign memresp_msg.data   = (req_q.type_ == mem_write) ? '0 : resp_data_q;

  cache_tag_array i_tags (
    .clk       (clk),
    .arst_n    (arst_n),
    .en        (ctrl.tag_en),
    .wen       (ctrl.tag_wen),
    .way       (wr_way),
    .index     (idx),
    .tag_in    (mem_addr.f.tag),
    .dirty_in  ((req_q.type_ == mem_write) && !ctrl.spill_sel),
    .lru_wen   (ctrl.lru_wen),
    .lru_in    (!wr_way),
    .tag_out0  (tag0),
    .tag_out1  (tag1),
    .valid_out (valid),
    .dirty_out (dirty),
    .lru_out   (lru)
  );

  cache_data_array i_data (
    .clk    (clk),
    .en     (ctrl.data_en),
    .wen    (ctrl.data_wen),
    .way    (wr_way),
    .index  (idx),
    .offset (off),
    .wdata  (ctrl.wdata_sel ? cache_resp_msg.data : req_q.data),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

endmodule

`default_nettype wire

//--- cache_ctrl.sv
// Cache controller FSM for lookup, response, spill, refill and flush.
// Drives every handshake of both ports and the datapath controls.
`default_nettype none

module cache_ctrl (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     memreq_val,
  input  logic                     memresp_rdy,
  input  logic                     cache_req_rdy,
  input  logic                     cache_resp_val,
  input  logic                     flush,
  input  cache_pkg::dpath_status_t status,
  output logic                     memreq_rdy,
  output logic                     memresp_val,
  output logic                     cache_req_val,
  output logic                     cache_resp_rdy,
  output logic                     flush_done,
  output cache_pkg::dpath_ctrl_t   ctrl,
  output cache_pkg::ctrl_state_e   state
);
  import cache_pkg::*;

  ctrl_state_e next_state;
  logic        live;
  logic        is_write;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      live  <= 1'b0;
    end else begin
      state <= next_state;
      live  <= 1'b1;
    end
  end

  // Handshake outputs; flush wins over a new request in idle
  assign memreq_rdy     = (state == st_idle) && live && !flush;
  assign memresp_val    = (state == st_respond);
  assign cache_req_val  = (state == st_spill) || (state == st_refill_req) ||
                          (state == st_flush_spill);
  assign cache_resp_rdy = (state == st_refill_wait);
  assign flush_done     = (state == st_flush_done);
  assign is_write       = (status.req_type == mem_write);

  // ==========================================================
  // Next state and datapath controls
  // ==========================================================
  always_comb begin
    next_state = state;
    ctrl       = '0;
    case (state)
      st_idle: begin
        ctrl.req_en   = memreq_val && memreq_rdy;
        ctrl.tag_en   = 1'b1;
        ctrl.data_en  = 1'b1;
        ctrl.word_clr = 1'b1;
        if (memreq_val && memreq_rdy) begin
          next_state = st_tag_check;
        end else if (live && flush) begin
          next_state = st_flush_scan;
        end
      end
      st_tag_check: begin
        // On a miss this access fetches word 0 of the victim
        ctrl.data_en = 1'b1;
        if (status.hit) begin
          ctrl.resp_en  = 1'b1;
          ctrl.lru_wen  = 1'b1;
          ctrl.tag_wen  = is_write;
          ctrl.data_wen = is_write;
          next_state    = st_respond;
        end else if (status.victim_dirty) begin
          next_state = st_spill;
        end else begin
          next_state = st_refill_req;
        end
      end
      st_respond: begin
        if (memresp_rdy) begin
          next_state = st_idle;
        end
      end
      st_spill, st_flush_spill: begin
        ctrl.spill_sel = 1'b1;
        ctrl.data_en   = 1'b1;
        ctrl.word_step = cache_req_rdy;
        if (cache_req_rdy && status.last_word) begin
          // Victim line is clean once its last word is out
          ctrl.tag_wen = 1'b1;
          next_state   = (state == st_spill) ? st_refill_req : st_flush_scan;
        end
      end
      st_refill_req: begin
        if (cache_req_rdy) begin
          next_state = st_refill_wait;
        end
      end
      st_refill_wait: begin
        if (cache_resp_val) begin
          ctrl.data_en   = 1'b1;
          ctrl.data_wen  = 1'b1;
          ctrl.wdata_sel = 1'b1;
          ctrl.resp_en   = 1'b1;
          ctrl.word_step = 1'b1;
          if (status.last_word) begin
            ctrl.tag_wen = 1'b1;
            ctrl.lru_wen = 1'b1;
            next_state   = is_write ? st_write_data : st_respond;
          end else begin
            next_state = st_refill_req;
          end
        end
      end
      st_write_data: begin
        ctrl.data_en  = 1'b1;
        ctrl.data_wen = 1'b1;
        ctrl.tag_wen  = 1'b1;
        next_state    = st_respond;
      end
      st_flush_scan: begin
        ctrl.tag_en  = 1'b1;
        ctrl.data_en = 1'b1;
        if (status.victim_dirty) begin
          next_state = st_flush_spill;
        end else begin
          ctrl.set_step = 1'b1;
          if (status.last_set) begin
            next_state = st_flush_done;
          end
        end
      end
      st_flush_done: begin
        next_state = st_idle;
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- cache_alt.sv
// Two-way write-back data cache top level.
// Joins the controller and the datapath between processor and memory ports.
`default_nettype none

module cache_alt (
  input  logic                 clk,
  input  logic                 arst_n,

  // Processor side
  input  logic                 memreq_val,
  output logic                 memreq_rdy,
  input  cache_pkg::mem_req_t  memreq_msg,
  output logic                 memresp_val,
  input  logic                 memresp_rdy,
  output cache_pkg::mem_resp_t memresp_msg,

  // Memory side
  output logic                 cache_req_val,
  input  logic                 cache_req_rdy,
  output cache_pkg::mem_req_t  cache_req_msg,
  input  logic                 cache_resp_val,
  output logic                 cache_resp_rdy,
  input  cache_pkg::mem_resp_t cache_resp_msg,

  input  logic                 flush,
  output logic                 flush_done
);
  import cache_pkg::*;

  dpath_ctrl_t   ctrl;
  dpath_status_t status;
  ctrl_state_e   state;

  cache_ctrl i_ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .memreq_val     (memreq_val),
    .memresp_rdy    (memresp_rdy),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp_val (cache_resp_val),
    .flush          (flush),
    .status         (status),
    .memreq_rdy     (memreq_rdy),
    .memresp_val    (memresp_val),
    .cache_req_val  (cache_req_val),
    .cache_resp_rdy (cache_resp_rdy),
    .flush_done     (flush_done),
    .ctrl           (ctrl),
    .state          (state)
  );

  cache_dpath i_dpath (
    .clk            (clk),
    .arst_n         (arst_n),
    .memreq_msg     (memreq_msg),
    .cache_resp_msg (cache_resp_msg),
    .ctrl           (ctrl),
    .state          (state),
    .memresp_msg    (memresp_msg),
    .cache_req_msg  (cache_req_msg),
    .status         (status)
  );

endmodule

`default_nettype wire

//--- tb_main_mem.sv
// Behavioral main memory for the cache testbench.
// Serves word reads after a fixed delay and stalls requests at random.
`default_nettype none

module tb_main_mem (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 req_val,
  output logic                 req_rdy,
  input  cache_pkg::mem_req_t  req_msg,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output cache_pkg::mem_resp_t resp_msg
);
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam logic [31:0] fill_key   = 32'h5a3c_96e1;
  localparam logic [15:0] lfsr_seed  = 16'd26556;
  localparam int          resp_delay = 2;

  logic [31:0] words [logic [31:0]];
  logic [15:0] lfsr;
  logic [31:0] rd_addr;
  logic        pending;
  logic        resp_fire;
  int          wait_cnt;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Untouched words hold their address mixed with a key
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (words.exists(addr)) begin
      return words[addr];
    end
    return addr ^ fill_key;
  endfunction

  initial begin
    req_rdy        = 1'b0;
    resp_val       = 1'b0;
    resp_msg       = '0;
    resp_msg.type_ = mem_read;
    lfsr           = lfsr_seed;
    pending        = 1'b0;
    resp_fire      = 1'b0;
    wait_cnt       = 0;
    rd_addr        = '0;
    forever begin
      // Transfers happen on the rising edge
      @(posedge clk);
      resp_fire = resp_val && resp_rdy;
      if (arst_n && req_val && req_rdy) begin
        if (req_msg.type_ == mem_write) begin
          words[req_msg.addr] = req_msg.data;
        end else begin
          rd_addr  = req_msg.addr;
          pending  = 1'b1;
          wait_cnt = resp_delay;
        end
      end
      @(negedge clk);
      if (resp_fire) begin
        resp_val = 1'b0;
        pending  = 1'b0;
      end else if (pending && !resp_val) begin
        if (wait_cnt > 0) begin
          wait_cnt--;
        end else begin
          resp_val      = 1'b1;
          resp_msg.data = read_word(rd_addr);
        end
      end
      // One LFSR bit per stall decision
      if (pending) begin
        req_rdy = 1'b0;
      end else begin
        lfsr    = lfsr_next(lfsr);
        req_rdy = ~lfsr[0];
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_cache_alt.sv
// Testbench for the two-way write-back data cache.
// Directed tests against a shadow memory, with a stalling main memory.
`default_nettype none

module tb_cache_alt;
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam logic [31:0] fill_key       = 32'h5a3c_96e1;
  localparam int          accesses       = 100;
  localparam int          cycles_per_acc = 40;
  localparam int          max_cycles     = accesses * cycles_per_acc;

  logic      clk = 1'b0;
  logic      arst_n;
  logic      memreq_val;
  logic      memreq_rdy;
  mem_req_t  memreq_msg;
  logic      memresp_val;
  logic      memresp_rdy;
  mem_resp_t memresp_msg;
  logic      cache_req_val;
  logic      cache_req_rdy;
  mem_req_t  cache_req_msg;
  logic      cache_resp_val;
  logic      cache_resp_rdy;
  mem_resp_t cache_resp_msg;
  logic      flush;
  logic      flush_done;

  logic [31:0] shadow      [logic [31:0]];
  bit          dirty_lines [logic [31:0]];
  mem_req_t    req_log [$];
  mem_req_t    exp_log [$];
  int          cycle_cnt = 0;
  int          errors = 0;

  always #5 clk = ~clk;

  cache_alt i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memreq_msg     (memreq_msg),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .memresp_msg    (memresp_msg),
    .cache_req_val  (cache_req_val),
    .cache_req_rdy  (cache_req_rdy),
    .cache_req_msg  (cache_req_msg),
    .cache_resp_val (cache_resp_val),
    .cache_resp_rdy (cache_resp_rdy),
    .cache_resp_msg (cache_resp_msg),
    .flush          (flush),
    .flush_done     (flush_done)
  );

  tb_main_mem i_mem (
    .clk      (clk),
    .arst_n   (arst_n),
    .req_val  (cache_req_val),
    .req_rdy  (cache_req_rdy),
    .req_msg  (cache_req_msg),
    .resp_val (cache_resp_val),
    .resp_rdy (cache_resp_rdy),
    .resp_msg (cache_resp_msg)
  );

  // Every memory-side transfer, in order
  always @(posedge clk) begin
    if (arst_n && cache_req_val && cache_req_rdy) begin
      req_log.push_back(cache_req_msg);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      abort_run();
    end
  end

  // ==========================================================
  // Checks
  // ==========================================================
  task automatic abort_run;
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_resp(input string name, input mem_resp_t exp, input mem_resp_t act);
    if (act.type_ !== exp.type_ || act.data !== exp.data) begin
      $display("[ERROR] %s: expected type %0d data %h, actual type %0d data %h",
               name, exp.type_, exp.data, act.type_, act.data);
      errors++;
      abort_run();
    end
  endtask

  // Read requests carry no data worth comparing
  task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act.type_ !== exp.type_ || act.addr !== exp.addr ||
        (exp.type_ == mem_write && act.data !== exp.data)) begin
      $display("[ERROR] %s: expected type %0d addr %h data %h, actual type %0d addr %h data %h",
               name, exp.type_, exp.addr, exp.data, act.type_, act.addr, act.data);
      errors++;
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      errors++;
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      errors++;
      abort_run();
    end
  endtask

  // ==========================================================
  // Shadow memory and expected traffic
  // ==========================================================
  function automatic logic [31:0] expect_word(input logic [31:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return addr ^ fill_key;
  endfunction

  function automatic logic [31:0] line_of(input logic [31:0] addr);
    return addr & ~32'(words_per_line * 4 - 1);
  endfunction

  // Four word requests for one line, lowest word first
  task automatic expect_line(input mem_type_e kind, input logic [31:0] line);
    mem_req_t r;
    int       w;
    for (w = 0; w < words_per_line; w++) begin
      r       = '0;
      r.type_ = kind;
      r.addr  = line + 32'(4 * w);
      r.data  = (kind == mem_write) ? expect_word(r.addr) : 32'h0;
      exp_log.push_back(r);
    end
  endtask

  task automatic check_log(input string name);
    int i;
    check_count({name, " memory requests"}, exp_log.size(), req_log.size());
    for (i = 0; i < exp_log.size(); i++) begin
      check_req($sformatf("%s request %0d", name, i), exp_log[i], req_log[i]);
    end
    exp_log.delete();
    req_log.delete();
  endtask

  // ==========================================================
  // Processor access and flush
  // ==========================================================
  task automatic do_access(input string name, input mem_type_e kind, input logic [31:0] addr,
                           input logic [31:0] wdata, input int hold, output int lat);
    mem_resp_t exp;
    mem_resp_t held;
    int        i;
    memreq_msg  = '{type_: kind, opaque: 8'h00, addr: addr, len: 2'b00, data: wdata};
    memreq_val  = 1'b1;
    memresp_rdy = (hold == 0);
    while (!memreq_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    @(negedge clk);
    memreq_val = 1'b0;
    lat        = 1;
    while (!memresp_val) begin
      @(negedge clk);
      lat++;
    end
    exp       = '0;
    exp.type_ = kind;
    if (kind == mem_write) begin
      shadow[addr]                = wdata;
      dirty_lines[line_of(addr)]  = 1'b1;
    end else begin
      exp.data = expect_word(addr);
    end
    check_resp(name, exp, memresp_msg);
    held = memresp_msg;
    // Response must wait, unchanged, while the processor is not ready
    for (i = 0; i < hold; i++) begin
      @(negedge clk);
      check_bit({name, " response held"}, 1'b1, memresp_val);
      check_bit({name, " request blocked"}, 1'b0, memreq_rdy);
      check_resp({name, " message held"}, held, memresp_msg);
    end
    memresp_rdy = 1'b1;
    @(posedge clk);
    @(negedge clk);
  endtask

  // Dirty lines are spilled in set order, one per set here
  task automatic run_flush(input string name);
    int s;
    for (s = 0; s < num_sets; s++) begin
      foreach (dirty_lines[key]) begin
        if (key[2 + off_bits +: idx_bits] == idx_bits'(s)) begin
          expect_line(mem_write, key);
        end
      end
    end
    dirty_lines.delete();
    check_bit({name, " flush_done before"}, 1'b0, flush_done);
    flush = 1'b1;
    @(posedge clk);
    @(negedge clk);
    flush = 1'b0;
    while (!flush_done) begin
      @(negedge clk);
    end
    @(negedge clk);
    check_bit({name, " flush_done pulse"}, 1'b0, flush_done);
    check_log(name);
  endtask

  // ==========================================================
  // Tests
  // ==========================================================
  task automatic test_read_miss_hit;
    int lat;
    do_access("read miss", mem_read, 32'h0000_1024, 32'h0, 0, lat);
    expect_line(mem_read, 32'h0000_1020);
    check_log("read miss");
    do_access("read hit", mem_read, 32'h0000_1024, 32'h0, 0, lat);
    check_count("read hit latency", 2, lat);
    check_log("read hit");
  endtask

  task automatic test_write_hit;
    int lat;
    do_access("write hit", mem_write, 32'h0000_1024, 32'hcafe_0001, 0, lat);
    check_count("write hit latency", 2, lat);
    check_log("write hit");
    do_access("read back", mem_read, 32'h0000_1024, 32'h0, 0, lat);
    check_count("read back latency", 2, lat);
    check_log("read back");
  endtask

  // Three lines in set 5
  task automatic test_lru_writeback;
    int lat;
    do_access("write miss", mem_write, 32'h0000_2054, 32'h1111_2222, 0, lat);
    expect_line(mem_read, 32'h0000_2050);
    check_log("write miss");
    do_access("fill second way", mem_read, 32'h0000_3058, 32'h0, 0, lat);
    expect_line(mem_read, 32'h0000_3050);
    check_log("fill second way");
    do_access("evict dirty", mem_read, 32'h0000_405c, 32'h0, 0, lat);
    expect_line(mem_write, 32'h0000_2050);
    expect_line(mem_read, 32'h0000_4050);
    check_log("evict dirty");
    dirty_lines.delete(32'h0000_2050);
    // Written word comes back from memory
    do_access("evict clean", mem_read, 32'h0000_2054, 32'h0, 0, lat);
    expect_line(mem_read, 32'h0000_2050);
    check_log("evict clean");
  endtask

  task automatic test_flush;
    logic [31:0] addrs [4];
    int          lat;
    int          i;
    do_access("write set 0", mem_write, 32'h0000_5000, 32'h0505_0000, 0, lat);
    do_access("write set 3", mem_write, 32'h0000_5034, 32'h0505_0003, 0, lat);
    do_access("write set 6", mem_write, 32'h0000_5068, 32'h0505_0006, 0, lat);
    req_log.delete();
    run_flush("flush");
    addrs = '{32'h0000_1024, 32'h0000_5000, 32'h0000_5034, 32'h0000_5068};
    for (i = 0; i < 4; i++) begin
      do_access($sformatf("read after flush %0d", i), mem_read, addrs[i], 32'h0, 0, lat);
      check_count("read after flush latency", 2, lat);
      check_log("read after flush");
    end
    run_flush("clean flush");
  endtask

  task automatic test_backpressure;
    logic [31:0] a;
    int          lat;
    int          s;
    do_access("held hit", mem_read, 32'h0000_1024, 32'h0, 5, lat);
    check_count("held hit latency", 2, lat);
    for (s = 0; s < num_sets; s++) begin
      a = 32'h0000_7000 + 32'(s * 16) + 32'(4 * (s % words_per_line));
      do_access($sformatf("held write %0d", s), mem_write, a, 32'h7700_0000 + 32'(s), 3, lat);
    end
    for (s = 0; s < num_sets; s++) begin
      a = 32'h0000_7000 + 32'(s * 16) + 32'(4 * (s % words_per_line));
      do_access($sformatf("held read %0d", s), mem_read, a, 32'h0, 2, lat);
    end
    // Older lines after evictions
    do_access("old line 0", mem_read, 32'h0000_2054, 32'h0, 1, lat);
    do_access("old line 1", mem_read, 32'h0000_3058, 32'h0, 1, lat);
    do_access("old line 2", mem_read, 32'h0000_5034, 32'h0, 1, lat);
    req_log.delete();
  endtask

  initial begin
    arst_n      = 1'b0;
    memreq_val  = 1'b0;
    memreq_msg  = '0;
    memresp_rdy = 1'b1;
    flush       = 1'b0;
    repeat (3) @(negedge clk);
    check_bit("reset memreq_rdy", 1'b0, memreq_rdy);
    check_bit("reset memresp_val", 1'b0, memresp_val);
    check_bit("reset cache_req_val", 1'b0, cache_req_val);
    check_bit("reset cache_resp_rdy", 1'b0, cache_resp_rdy);
    check_bit("reset flush_done", 1'b0, flush_done);
    arst_n = 1'b1;
    @(negedge clk);
    test_read_miss_hit();
    test_write_hit();
    test_lru_writeback();
    test_flush();
    test_backpressure();
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_dpath.sv
cache_ctrl.sv
cache_alt.sv
tb_main_mem.sv
tb_cache_alt.sv

//--- Makefile
# Verilator flow for the cache and its testbench

TOP := tb_cache_alt

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
